// ==== run_sim.sh ====
#!/bin/sh
# Build and run the white balance testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module wb_tb -Mdir obj_dir -f wb_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vwb_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

// ==== source/frame_stats.sv ====
`timescale 1ns/1ps

module frame_stats
    import video_pkg::*;
    import wb_pkg::*;
#(
    parameter  int H_ACT = 1280,
    parameter  int V_ACT = 720,
    localparam int SUM_W = sum_width(PIX_W, H_ACT, V_ACT)
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_vsync,
    input  logic             i_de,
    input  pixel_t           i_r,
    input  pixel_t           i_g,
    input  pixel_t           i_b,
    output logic [SUM_W-1:0] o_sum_r,
    output logic [SUM_W-1:0] o_sum_g,
    output logic [SUM_W-1:0] o_sum_b,
    output logic             o_stats_valid
);

    logic             vsync_q;
    logic             vsync_rise;
    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;

    assign vsync_rise = i_vsync & ~vsync_q;

    // running sums restart on the frame boundary.
    // a pixel sampled on the edge itself already belongs to the new frame.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vsync_q       <= 1'b0;
            o_stats_valid <= 1'b0;
            acc_r         <= '0;
            acc_g         <= '0;
            acc_b         <= '0;
        end else begin
            vsync_q       <= i_vsync;
            o_stats_valid <= vsync_rise;
            if (vsync_rise) begin
                acc_r <= i_de ? SUM_W'(i_r) : '0;
                acc_g <= i_de ? SUM_W'(i_g) : '0;
                acc_b <= i_de ? SUM_W'(i_b) : '0;
            end else if (i_de) begin
                acc_r <= acc_r + SUM_W'(i_r);
                acc_g <= acc_g + SUM_W'(i_g);
                acc_b <= acc_b + SUM_W'(i_b);
            end
        end
    end

    // finished frame totals stay here until the next edge.
    always_ff @(posedge clk) begin
        if (vsync_rise) begin
            o_sum_r <= acc_r;
            o_sum_g <= acc_g;
            o_sum_b <= acc_b;
        end
    end

endmodule : frame_stats

// ==== source/gain_apply.sv ====
`timescale 1ns/1ps

module gain_apply
    import video_pkg::*;
    import wb_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_vsync,
    input  logic   i_hsync,
    input  logic   i_de,
    input  pixel_t i_r,
    input  pixel_t i_g,
    input  pixel_t i_b,
    input  gain_t  i_gain_r,
    input  gain_t  i_gain_g,
    input  gain_t  i_gain_b,
    output logic   o_vsync,
    output logic   o_hsync,
    output logic   o_de,
    output pixel_t o_r,
    output pixel_t o_g,
    output pixel_t o_b
);

    localparam int     PROD_W  = PIX_W + GAIN_W;
    localparam pixel_t PIX_MAX = '1;

    logic [PROD_W-1:0] prod_r;
    logic [PROD_W-1:0] prod_g;
    logic [PROD_W-1:0] prod_b;
    logic              vsync_d1;
    logic              hsync_d1;
    logic              de_d1;

    // drop the fraction, then saturate to the pixel range.
    function automatic pixel_t scale_sat(input logic [PROD_W-1:0] prod);
        logic [PROD_W-GAIN_FRAC-1:0] scaled;
        scaled = prod[PROD_W-1:GAIN_FRAC];
        if (scaled > (PROD_W-GAIN_FRAC)'(PIX_MAX)) begin
            return PIX_MAX;
        end
        return scaled[PIX_W-1:0];
    endfunction

    // stage one registers the full products.
    always_ff @(posedge clk) begin
        prod_r <= PROD_W'(i_r) * PROD_W'(i_gain_r);
        prod_g <= PROD_W'(i_g) * PROD_W'(i_gain_g);
        prod_b <= PROD_W'(i_b) * PROD_W'(i_gain_b);
    end

    // stage two scales the data while sync follows through two registers.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vsync_d1 <= 1'b0;
            hsync_d1 <= 1'b0;
            de_d1    <= 1'b0;
            o_vsync  <= 1'b0;
            o_hsync  <= 1'b0;
            o_de     <= 1'b0;
            o_r      <= '0;
            o_g      <= '0;
            o_b      <= '0;
        end else begin
            vsync_d1 <= i_vsync;
            hsync_d1 <= i_hsync;
            de_d1    <= i_de;
            o_vsync  <= vsync_d1;
            o_hsync  <= hsync_d1;
            o_de     <= de_d1;
            // blanking pixels leave as black.
            o_r      <= de_d1 ? scale_sat(prod_r) : '0;
            o_g      <= de_d1 ? scale_sat(prod_g) : '0;
            o_b      <= de_d1 ? scale_sat(prod_b) : '0;
        end
    end

endmodule : gain_apply

// ==== source/gain_calc.sv ====
`timescale 1ns/1ps

module gain_calc
    import video_pkg::*;
    import wb_pkg::*;
#(
    parameter  int H_ACT = 1280,
    parameter  int V_ACT = 720,
    localparam int SUM_W = sum_width(PIX_W, H_ACT, V_ACT)
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic [SUM_W-1:0] i_sum_r,
    input  logic [SUM_W-1:0] i_sum_g,
    input  logic [SUM_W-1:0] i_sum_b,
    input  logic             i_stats_valid,
    output gain_t            o_gain_r,
    output gain_t            o_gain_g,
    output gain_t            o_gain_b
);

    localparam int TOT_W = SUM_W + 2;
    localparam int DIV_W = div_width(SUM_W);

    typedef enum logic [1:0] {st_idle, st_start, st_wait, st_load} state_e;

    state_e           state;
    chan_e            chan;
    logic [TOT_W-1:0] total_q;
    logic [SUM_W-1:0] sum_sel;
    logic [TOT_W-1:0] sum_x3;
    logic             div_start;
    logic             div_done;
    logic [DIV_W-1:0] dividend;
    logic [DIV_W-1:0] divisor;
    logic [DIV_W-1:0] quotient;
    gain_t            gain_clamped;
    gain_t            pend_r;
    gain_t            pend_g;
    gain_t            pend_b;

    always_comb begin
        case (chan)
            chan_red:   sum_sel = i_sum_r;
            chan_green: sum_sel = i_sum_g;
            default:    sum_sel = i_sum_b;
        endcase
    end

    // gain = (total / 3) / sum, scaled to GAIN_FRAC bits.
    assign sum_x3    = TOT_W'({sum_sel, 1'b0}) + TOT_W'(sum_sel);
    assign dividend  = {total_q, {GAIN_FRAC{1'b0}}};
    assign divisor   = {{GAIN_FRAC{1'b0}}, sum_x3};
    assign div_start = (state == st_start);

    assign gain_clamped = (sum_sel == '0 || quotient > DIV_W'(GAIN_MAX)) ?
                          GAIN_MAX : quotient[GAIN_W-1:0];

    wb_divider #(.DIV_W(DIV_W)) wb_divider_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_start   (div_start),
        .i_dividend(dividend),
        .i_divisor (divisor),
        .o_quotient(quotient),
        .o_done    (div_done)
    );

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state    <= st_idle;
            chan     <= chan_red;
            o_gain_r <= GAIN_ONE;
            o_gain_g <= GAIN_ONE;
            o_gain_b <= GAIN_ONE;
        end else begin
            case (state)
                st_idle: begin
                    if (i_stats_valid) begin
                        chan  <= chan_red;
                        state <= st_start;
                    end
                end
                st_start: state <= st_wait;
                st_wait: begin
                    if (div_done) begin
                        if (chan == chan_blue) begin
                            state <= st_load;
                        end else begin
                            chan  <= (chan == chan_red) ? chan_green : chan_blue;
                            state <= st_start;
                        end
                    end
                end
                // all three gains switch in the same cycle.
                st_load: begin
                    o_gain_r <= pend_r;
                    o_gain_g <= pend_g;
                    o_gain_b <= pend_b;
                    state    <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && i_stats_valid) begin
            total_q <= TOT_W'(i_sum_r) + TOT_W'(i_sum_g) + TOT_W'(i_sum_b);
        end
        if (state == st_wait && div_done) begin
            case (chan)
                chan_red:   pend_r <= gain_clamped;
                chan_green: pend_g <= gain_clamped;
                default:    pend_b <= gain_clamped;
            endcase
        end
    end

endmodule : gain_calc

// ==== source/video_pkg.sv ====
package video_pkg;

    // width of one color channel.
    localparam int PIX_W = 8;

    // one unsigned color channel value.
    typedef logic [PIX_W-1:0] pixel_t;

    // channel index, in the order the gain divisions run.
    typedef enum logic [1:0] {
        chan_red   = 2'd0,
        chan_green = 2'd1,
        chan_blue  = 2'd2
    } chan_e;

endpackage : video_pkg

// ==== source/wb_divider.sv ====
`timescale 1ns/1ps

module wb_divider #(
    parameter int DIV_W = 32
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic [DIV_W-1:0] i_dividend,
    input  logic [DIV_W-1:0] i_divisor,
    output logic [DIV_W-1:0] o_quotient,
    output logic             o_done
);

    localparam int CNT_W = $clog2(DIV_W + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [DIV_W-1:0] rem_q;
    logic [DIV_W-1:0] quo_q;
    logic [DIV_W-1:0] dsr_q;
    logic [DIV_W:0]   shifted;
    logic [DIV_W+1:0] trial;
    logic [DIV_W-1:0] rem_next;
    logic [DIV_W-1:0] quo_next;

    // one restoring step. the dividend shifts out of quo_q as quotient bits shift in.
    // with a zero divisor every trial succeeds, so the quotient comes out all ones.
    always_comb begin
        shifted = {rem_q, quo_q[DIV_W-1]};
        trial   = {1'b0, shifted} - {2'b00, dsr_q};
        if (trial[DIV_W+1]) begin
            rem_next = shifted[DIV_W-1:0];
            quo_next = {quo_q[DIV_W-2:0], 1'b0};
        end else begin
            rem_next = trial[DIV_W-1:0];
            quo_next = {quo_q[DIV_W-2:0], 1'b1};
        end
    end

    // step counter. done rises with the last step, DIV_W+1 cycles after start.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + CNT_W'(1);
                if (cnt == CNT_W'(DIV_W - 1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            rem_q <= '0;
            quo_q <= i_dividend;
            dsr_q <= i_divisor;
        end else if (busy) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    // quotient stays put once the steps stop.
    assign o_quotient = quo_q;

endmodule : wb_divider

// ==== source/wb_pkg.sv ====
package wb_pkg;

    // gain format is unsigned 2.8 fixed point.
    localparam int GAIN_W    = 10;
    localparam int GAIN_FRAC = 8;

    typedef logic [GAIN_W-1:0] gain_t;

    // 1.0 and just under 4.0.
    localparam gain_t GAIN_ONE = 10'd256;
    localparam gain_t GAIN_MAX = 10'd1023;

    // bits needed to hold one channel summed over a full active frame.
    function automatic int sum_width(input int pix_w, input int h_act, input int v_act);
        longint peak;
        peak = ((longint'(1) << pix_w) - 1) * longint'(h_act) * longint'(v_act);
        return $clog2(peak + 1);
    endfunction

    // the total of three sums needs two more bits, then it is scaled by GAIN_FRAC.
    function automatic int div_width(input int sum_w);
        return sum_w + 2 + GAIN_FRAC;
    endfunction

endpackage : wb_pkg

// ==== source/wb_top.sv ====
`timescale 1ns/1ps

module wb_top
    import video_pkg::*;
    import wb_pkg::*;
#(
    parameter  int H_ACT = 1280,
    parameter  int V_ACT = 720,
    localparam int SUM_W = sum_width(PIX_W, H_ACT, V_ACT)
) (
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_vsync,
    input  logic   i_hsync,
    input  logic   i_de,
    input  pixel_t i_r,
    input  pixel_t i_g,
    input  pixel_t i_b,
    output logic   o_vsync,
    output logic   o_hsync,
    output logic   o_de,
    output pixel_t o_r,
    output pixel_t o_g,
    output pixel_t o_b,
    output gain_t  o_gain_r,
    output gain_t  o_gain_g,
    output gain_t  o_gain_b
);

    logic [SUM_W-1:0] sum_r;
    logic [SUM_W-1:0] sum_g;
    logic [SUM_W-1:0] sum_b;
    logic             stats_valid;

    // statistics of the current frame.
    frame_stats #(.H_ACT(H_ACT), .V_ACT(V_ACT)) frame_stats_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_vsync      (i_vsync),
        .i_de         (i_de),
        .i_r          (i_r),
        .i_g          (i_g),
        .i_b          (i_b),
        .o_sum_r      (sum_r),
        .o_sum_g      (sum_g),
        .o_sum_b      (sum_b),
        .o_stats_valid(stats_valid)
    );

    // gains are computed in blanking and apply from the next frame on.
    gain_calc #(.H_ACT(H_ACT), .V_ACT(V_ACT)) gain_calc_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_sum_r      (sum_r),
        .i_sum_g      (sum_g),
        .i_sum_b      (sum_b),
        .i_stats_valid(stats_valid),
        .o_gain_r     (o_gain_r),
        .o_gain_g     (o_gain_g),
        .o_gain_b     (o_gain_b)
    );

    gain_apply gain_apply_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_vsync (i_vsync),
        .i_hsync (i_hsync),
        .i_de    (i_de),
        .i_r     (i_r),
        .i_g     (i_g),
        .i_b     (i_b),
        .i_gain_r(o_gain_r),
        .i_gain_g(o_gain_g),
        .i_gain_b(o_gain_b),
        .o_vsync (o_vsync),
        .o_hsync (o_hsync),
        .o_de    (o_de),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b)
    );

endmodule : wb_top

// ==== verif/wb_tb.sv ====
`timescale 1ns/1ps

module wb_tb
    import video_pkg::*;
    import wb_pkg::*;
();

    localparam int          H_ACT       = 16;
    localparam int          V_ACT       = 8;
    localparam int          H_BLANK     = 4;
    localparam int          V_BLANK     = 220;
    localparam int          VS_START    = 10;
    localparam int          VS_LEN      = 5;
    localparam int          N_FRAMES    = 7;
    localparam int          FRAME_CYC   = V_ACT * (H_ACT + H_BLANK) + V_BLANK;
    localparam int          WATCHDOG_NS = N_FRAMES * FRAME_CYC * 4 + 2000;
    localparam logic [31:0] LFSR_SEED   = 32'h8f64c7a0;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

    // one row of the frame table.
    typedef struct packed {
        logic   noisy;
        pixel_t r;
        pixel_t g;
        pixel_t b;
        logic   sat;
    } frame_t;

    // expected outputs of one cycle.
    typedef struct packed {
        logic   vs;
        logic   hs;
        logic   de;
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } expect_t;

    logic        clk;
    logic        i_rst_n;
    logic        i_vsync;
    logic        i_hsync;
    logic        i_de;
    pixel_t      i_r;
    pixel_t      i_g;
    pixel_t      i_b;
    logic        o_vsync;
    logic        o_hsync;
    logic        o_de;
    pixel_t      o_r;
    pixel_t      o_g;
    pixel_t      o_b;
    gain_t       o_gain_r;
    gain_t       o_gain_g;
    gain_t       o_gain_b;
    logic [31:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          acc_r;
    int          acc_g;
    int          acc_b;
    logic        sat_seen;
    gain_t       exp_gain_r;
    gain_t       exp_gain_g;
    gain_t       exp_gain_b;
    expect_t     exp_q[$];

    wb_top #(.H_ACT(H_ACT), .V_ACT(V_ACT)) wb_top_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_vsync (i_vsync),
        .i_hsync (i_hsync),
        .i_de    (i_de),
        .i_r     (i_r),
        .i_g     (i_g),
        .i_b     (i_b),
        .o_vsync (o_vsync),
        .o_hsync (o_hsync),
        .o_de    (o_de),
        .o_r     (o_r),
        .o_g     (o_g),
        .o_b     (o_b),
        .o_gain_r(o_gain_r),
        .o_gain_g(o_gain_g),
        .o_gain_b(o_gain_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the frame sequence did not finish in time");
        $display("Checks failed");
        $finish;
    end

    // frames 0 and 6 are gray and frame 4 has no green at all.
    function automatic frame_t frame_row(input int idx);
        frame_t row;
        case (idx)
            0:       row = '{1'b0, 8'd100, 8'd100, 8'd100, 1'b0};
            1:       row = '{1'b1, 8'd120, 8'd80,  8'd40,  1'b0};
            2:       row = '{1'b0, 8'd200, 8'd100, 8'd50,  1'b0};
            3:       row = '{1'b0, 8'd250, 8'd240, 8'd230, 1'b1};
            4:       row = '{1'b0, 8'd60,  8'd0,   8'd90,  1'b0};
            5:       row = '{1'b1, 8'd128, 8'd128, 8'd128, 1'b1};
            default: row = '{1'b0, 8'd70,  8'd70,  8'd70,  1'b0};
        endcase
        return row;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // mean of the three sums over this channel's sum in 2.8 format.
    function automatic gain_t compute_gain(input longint total, input longint sum);
        longint q;
        if (sum == 0) begin
            return GAIN_MAX;
        end
        q = (total << GAIN_FRAC) / (3 * sum);
        if (q > longint'(GAIN_MAX)) begin
            return GAIN_MAX;
        end
        return gain_t'(q);
    endfunction

    function automatic pixel_t expect_pixel(input pixel_t p, input gain_t g);
        int scaled;
        scaled = (int'(p) * int'(g)) >> GAIN_FRAC;
        if (scaled > 255) begin
            return 8'd255;
        end
        return pixel_t'(scaled);
    endfunction

    task automatic compare_pixel(input string name, input pixel_t expected,
                                 input pixel_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_gain(input chan_e ch, input gain_t expected, input gain_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: gain of %s expected %0d, actual %0d",
                     $time, ch.name(), expected, actual);
        end
    endtask

    task automatic compare_sync(input string name, input logic expected, input logic actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        compare_sync("o_vsync", e.vs, o_vsync);
        compare_sync("o_hsync", e.hs, o_hsync);
        compare_sync("o_de", e.de, o_de);
        compare_pixel("o_r", e.r, o_r);
        compare_pixel("o_g", e.g, o_g);
        compare_pixel("o_b", e.b, o_b);
    endtask

    task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                               input pixel_t r, input pixel_t g, input pixel_t b);
        expect_t e;
        expect_t due;
        @(posedge clk);
        #1;
        // the entry pushed two cycles ago is at the outputs now.
        if (exp_q.size() == 2) begin
            due = exp_q.pop_front();
            check_outputs(due);
            // full scale on an active output marks a saturated frame.
            if (due.de && (o_r == 8'd255 || o_g == 8'd255 || o_b == 8'd255)) begin
                sat_seen = 1'b1;
            end
        end
        i_vsync = vs;
        i_hsync = hs;
        i_de    = de;
        i_r     = r;
        i_g     = g;
        i_b     = b;
        e.vs = vs;
        e.hs = hs;
        e.de = de;
        e.r  = de ? expect_pixel(r, exp_gain_r) : '0;
        e.g  = de ? expect_pixel(g, exp_gain_g) : '0;
        e.b  = de ? expect_pixel(b, exp_gain_b) : '0;
        if (de) begin
            acc_r += int'(r);
            acc_g += int'(g);
            acc_b += int'(b);
        end
        exp_q.push_back(e);
    endtask

    task automatic play_frame(input int idx);
        frame_t row;
        int     nr;
        int     ng;
        int     nb;
        longint total;
        row      = frame_row(idx);
        acc_r    = 0;
        acc_g    = 0;
        acc_b    = 0;
        sat_seen = 1'b0;
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                nr = 0;
                ng = 0;
                nb = 0;
                if (row.noisy) begin
                    take_bits(4, nr);
                    take_bits(4, ng);
                    take_bits(4, nb);
                end
                drive_cycle(1'b0, 1'b0, 1'b1, row.r + pixel_t'(nr),
                            row.g + pixel_t'(ng), row.b + pixel_t'(nb));
            end
            repeat (H_BLANK) drive_cycle(1'b0, 1'b1, 1'b0, '0, '0, '0);
        end
        // the vsync edge hands the sums over and the gains settle within blanking.
        for (int v = 0; v < V_BLANK; v++) begin
            drive_cycle(v >= VS_START && v < VS_START + VS_LEN, 1'b0, 1'b0, '0, '0, '0);
        end
        total      = longint'(acc_r) + longint'(acc_g) + longint'(acc_b);
        exp_gain_r = compute_gain(total, longint'(acc_r));
        exp_gain_g = compute_gain(total, longint'(acc_g));
        exp_gain_b = compute_gain(total, longint'(acc_b));
        compare_gain(chan_red, exp_gain_r, o_gain_r);
        compare_gain(chan_green, exp_gain_g, o_gain_g);
        compare_gain(chan_blue, exp_gain_b, o_gain_b);
        n_checks++;
        if (sat_seen != row.sat) begin
            n_errors++;
            $display("frame %0d: output saturation is %b, but the frame table says %b",
                     idx, sat_seen, row.sat);
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_vsync    = 1'b0;
        i_hsync    = 1'b0;
        i_de       = 1'b0;
        i_r        = '0;
        i_g        = '0;
        i_b        = '0;
        lfsr       = LFSR_SEED;
        n_checks   = 0;
        n_errors   = 0;
        acc_r      = 0;
        acc_g      = 0;
        acc_b      = 0;
        sat_seen   = 1'b0;
        exp_gain_r = GAIN_ONE;
        exp_gain_g = GAIN_ONE;
        exp_gain_b = GAIN_ONE;
        repeat (2) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        // idle outputs and unity gains straight out of reset.
        check_outputs('0);
        compare_gain(chan_red, GAIN_ONE, o_gain_r);
        compare_gain(chan_green, GAIN_ONE, o_gain_g);
        compare_gain(chan_blue, GAIN_ONE, o_gain_b);
        for (int f = 0; f < N_FRAMES; f++) begin
            play_frame(f);
        end
        // flush the last two queued entries.
        repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0);
        $display("wb_tb: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : wb_tb

// ==== wb_top.f ====
source/video_pkg.sv
source/wb_pkg.sv
source/frame_stats.sv
source/wb_divider.sv
source/gain_calc.sv
source/gain_apply.sv
source/wb_top.sv
verif/wb_tb.sv
